// ==== udp_frame_mux.f ====
+incdir+.
udp_hdr_pkg.sv
udp_mux_pkg.sv
udp_frame_ctrl.sv
udp_hdr_reg.sv
axis_skid_buf.sv
udp_frame_mux.sv
tb_udp_frame_mux.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_udp_frame_mux
RTL_TOP    = udp_frame_mux
FILELIST   = udp_frame_mux.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Errors found
PASS_MSG   = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_udp_frame_mux_tasks.svh ====
`ifndef TB_UDP_FRAME_MUX_TASKS_SVH
`define TB_UDP_FRAME_MUX_TASKS_SVH

function automatic logic [31:0] rand32();
    return $random(seed);
endfunction

task automatic init_inputs();
    rst               <= 1'b1;
    enable            <= 1'b0;
    select            <= '0;
    s_hdr_valid       <= '0;
    s_ip_source_ip    <= '0;
    s_ip_dest_ip      <= '0;
    s_udp_source_port <= '0;
    s_udp_dest_port   <= '0;
    s_udp_length      <= '0;
    s_udp_checksum    <= '0;
    s_tvalid          <= '0;
    s_tdata           <= '0;
    s_tlast           <= '0;
    s_tuser           <= '0;
    m_hdr_ready       <= 1'b1;
    m_tready          <= 1'b1;
endtask

// random header and 1 to 16 payload bytes
task automatic build_frame(input logic [SEL_W-1:0] src);
    logic [31:0] r;
    r = rand32();
    fr_nbytes[src] = int'(r[3:0]) + 1;
    fr_user[src]   = r[4];
    fr_hdr[src]    = {rand32(), rand32(), rand32(), rand32()};
    // udp length counts the 8 byte header too
    fr_hdr[src][31:16] = 16'(fr_nbytes[src] + 8);
    for (int i = 0; i < MAX_BYTES; i++) begin
        r = rand32();
        fr_data[src][i[3:0]] = r[DATA_WIDTH-1:0];
    end
endtask

// header handshake first, then the payload bytes one per accepted beat
task automatic run_source(input logic [SEL_W-1:0] src, input int nframes);
    for (int f = 0; f < nframes; f++) begin
        build_frame(src);
        @(posedge clk);
        s_hdr_valid[src]       <= 1'b1;
        s_ip_source_ip[src]    <= fr_hdr[src][127:96];
        s_ip_dest_ip[src]      <= fr_hdr[src][95:64];
        s_udp_source_port[src] <= fr_hdr[src][63:48];
        s_udp_dest_port[src]   <= fr_hdr[src][47:32];
        s_udp_length[src]      <= fr_hdr[src][31:16];
        s_udp_checksum[src]    <= fr_hdr[src][15:0];
        do begin
            @(posedge clk);
        end while (!s_hdr_ready[src]);
        s_hdr_valid[src] <= 1'b0;
        for (int i = 0; i < fr_nbytes[src]; i++) begin
            s_tvalid[src] <= 1'b1;
            s_tdata[src]  <= fr_data[src][i[3:0]];
            s_tlast[src]  <= (i == fr_nbytes[src] - 1);
            s_tuser[src]  <= (i == fr_nbytes[src] - 1) && fr_user[src];
            do begin
                @(posedge clk);
            end while (!s_tready[src]);
        end
        s_tvalid[src] <= 1'b0;
        s_tlast[src]  <= 1'b0;
        s_tuser[src]  <= 1'b0;
    end
endtask

task automatic drive_select();
    logic [31:0] r;
    forever begin
        @(posedge clk);
        r = rand32();
        select <= r[SEL_W-1:0];
    end
endtask

// sink always ready until bp_on, then random stalls on both outputs
task automatic drive_ready();
    logic [31:0] r;
    forever begin
        @(posedge clk);
        r = rand32();
        if (bp_on) begin
            m_tready    <= (r[1:0] != 2'b00);
            m_hdr_ready <= r[2];
        end else begin
            m_tready    <= 1'b1;
            m_hdr_ready <= 1'b1;
        end
    end
endtask

`endif

// ==== tb_udp_frame_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_udp_frame_mux;

    localparam int S_COUNT        = 4;
    localparam int DATA_WIDTH     = 8;
    localparam int SEL_W          = $clog2(S_COUNT);
    localparam int MAX_BYTES      = 16;
    localparam int FRAMES_PER_SRC = 6;
    localparam int TOTAL_FRAMES   = S_COUNT * FRAMES_PER_SRC;
    // every frame at full length, stalled on most cycles, plus reset and gating
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * (MAX_BYTES + 4) * 4 + 200;

    logic                               clk = 1'b0;
    logic                               rst;
    logic                               enable;
    logic [SEL_W-1:0]                   select;
    logic [S_COUNT-1:0]                 s_hdr_valid;
    wire  [S_COUNT-1:0]                 s_hdr_ready;
    logic [S_COUNT-1:0][31:0]           s_ip_source_ip;
    logic [S_COUNT-1:0][31:0]           s_ip_dest_ip;
    logic [S_COUNT-1:0][15:0]           s_udp_source_port;
    logic [S_COUNT-1:0][15:0]           s_udp_dest_port;
    logic [S_COUNT-1:0][15:0]           s_udp_length;
    logic [S_COUNT-1:0][15:0]           s_udp_checksum;
    logic [S_COUNT-1:0]                 s_tvalid;
    wire  [S_COUNT-1:0]                 s_tready;
    logic [S_COUNT-1:0][DATA_WIDTH-1:0] s_tdata;
    logic [S_COUNT-1:0]                 s_tlast;
    logic [S_COUNT-1:0]                 s_tuser;
    wire                                m_hdr_valid;
    logic                               m_hdr_ready;
    wire  [31:0]                        m_ip_source_ip;
    wire  [31:0]                        m_ip_dest_ip;
    wire  [15:0]                        m_udp_source_port;
    wire  [15:0]                        m_udp_dest_port;
    wire  [15:0]                        m_udp_length;
    wire  [15:0]                        m_udp_checksum;
    wire                                m_tvalid;
    logic                               m_tready;
    wire  [DATA_WIDTH-1:0]              m_tdata;
    wire                                m_tlast;
    wire                                m_tuser;

    // frame each source is offering now
    // header word is {src ip, dst ip, src port, dst port, length, checksum}
    logic [127:0]          fr_hdr [S_COUNT];
    logic [DATA_WIDTH-1:0] fr_data [S_COUNT][MAX_BYTES];
    int                    fr_nbytes [S_COUNT];
    logic                  fr_user [S_COUNT];

    logic [127:0]          exp_hdr_q[$];
    logic [DATA_WIDTH+1:0] exp_beat_q[$];
    logic [SEL_W-1:0]      active_src = '0;
    logic [SEL_W-1:0]      prev_select = '0;
    logic                  prev_enable = 1'b0;
    logic                  bp_on;
    int                    started = 0;
    int                    out_frames = 0;
    int                    cycles = 0;
    int                    seed = 32'hef3f_e200;

    always #20 clk = ~clk;

    udp_frame_mux #(
        .S_COUNT    (S_COUNT),
        .DATA_WIDTH (DATA_WIDTH)
    ) dut_i (.*);

    `include "tb_udp_frame_mux_tasks.svh"

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s got %0h expected %0h", $time, what, got, exp));
        end
    endtask

    // the whole header of the accepted frame comes out unchanged
    function automatic logic [127:0] expected_header(input logic [SEL_W-1:0] src);
        return fr_hdr[src];
    endfunction

    // expected beat is {data, last, user} with user only on the last byte
    function automatic logic [DATA_WIDTH+1:0] expected_beat(input logic [SEL_W-1:0] src,
                                                            input int idx);
        logic last;
        last = (idx == fr_nbytes[src] - 1);
        return {fr_data[src][idx[3:0]], last, last && fr_user[src]};
    endfunction

    task automatic queue_frame(input logic [SEL_W-1:0] src);
        exp_hdr_q.push_back(expected_header(src));
        for (int i = 0; i < fr_nbytes[src]; i++) begin
            exp_beat_q.push_back(expected_beat(src, i));
        end
    endtask

    // monitor samples on the edge that ends each cycle
    always @(posedge clk) begin
        logic [SEL_W-1:0]      src;
        logic [127:0]          exp_hdr;
        logic [DATA_WIDTH+1:0] exp_beat;
        if (!rst) begin
            if (s_hdr_ready != '0) begin
                src = '0;
                for (int i = 0; i < S_COUNT; i++) begin
                    if (s_hdr_ready[i]) begin
                        src = SEL_W'(i);
                    end
                end
                if (!$onehot(s_hdr_ready)) begin
                    abort_run("header ready raised on more than one source");
                end else if (!prev_enable || prev_select != src || !s_hdr_valid[src]) begin
                    abort_run("header ready went to a source that was not selected and waiting");
                end else begin
                    queue_frame(src);
                    active_src = src;
                    started++;
                end
            end
            if (s_tready != '0 && s_tready != (S_COUNT'(1) << active_src)) begin
                abort_run("payload ready raised on a source that does not own the frame");
            end
            if (m_hdr_valid && m_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    abort_run("output header appeared with no frame accepted from a source");
                end else begin
                    exp_hdr = exp_hdr_q.pop_front();
                    check_value("output header", {m_ip_source_ip, m_ip_dest_ip,
                                m_udp_source_port, m_udp_dest_port, m_udp_length,
                                m_udp_checksum}, exp_hdr);
                end
            end
            if (m_tvalid && m_tready) begin
                if (exp_beat_q.size() == 0) begin
                    abort_run("output payload beat appeared with no byte expected");
                end else begin
                    exp_beat = exp_beat_q.pop_front();
                    check_value("output payload beat", 128'({m_tdata, m_tlast, m_tuser}),
                                128'(exp_beat));
                    if (m_tlast) begin
                        out_frames++;
                    end
                end
            end
        end
        prev_select = select;
        prev_enable = enable;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d frames came out",
                                cycles, out_frames, TOTAL_FRAMES));
        end
    end

    initial begin
        bp_on = 1'b0;
        init_inputs();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            check_value("idle outputs after reset",
                        128'({s_hdr_ready, s_tready, m_hdr_valid, m_tvalid}), 128'(0));
        end
        // all sources offer frames while the mux is still disabled
        select <= SEL_W'(2);
        fork
            run_source(SEL_W'(0), FRAMES_PER_SRC);
            run_source(SEL_W'(1), FRAMES_PER_SRC);
            run_source(SEL_W'(2), FRAMES_PER_SRC);
            run_source(SEL_W'(3), FRAMES_PER_SRC);
        join_none
        repeat (20) begin
            @(posedge clk);
            check_value("outputs while disabled",
                        128'({s_hdr_ready, s_tready, m_hdr_valid, m_tvalid}), 128'(0));
        end
        enable <= 1'b1;
        while (started == 0) begin
            @(posedge clk);
        end
        // select now changes every cycle including mid frame
        fork
            drive_select();
            drive_ready();
        join_none
        while (out_frames < TOTAL_FRAMES || exp_hdr_q.size() != 0) begin
            @(posedge clk);
            if (out_frames >= TOTAL_FRAMES / 2) begin
                bp_on = 1'b1;
            end
        end
        repeat (4) @(posedge clk);
        if (started != TOTAL_FRAMES || exp_beat_q.size() != 0) begin
            abort_run("frames still outstanding at the end of the run");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== udp_frame_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_frame_mux #(
    parameter int S_COUNT    = 4,
    parameter int DATA_WIDTH = 8
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         enable,
    input  wire [udp_mux_pkg::src_index_w(S_COUNT)-1:0] select,

    // source headers
    input  wire [S_COUNT-1:0]                           s_hdr_valid,
    output wire [S_COUNT-1:0]                           s_hdr_ready,
    input  wire udp_hdr_pkg::ip_addr_t  [S_COUNT-1:0]   s_ip_source_ip,
    input  wire udp_hdr_pkg::ip_addr_t  [S_COUNT-1:0]   s_ip_dest_ip,
    input  wire udp_hdr_pkg::udp_port_t [S_COUNT-1:0]   s_udp_source_port,
    input  wire udp_hdr_pkg::udp_port_t [S_COUNT-1:0]   s_udp_dest_port,
    input  wire udp_hdr_pkg::udp_len_t  [S_COUNT-1:0]   s_udp_length,
    input  wire udp_hdr_pkg::udp_csum_t [S_COUNT-1:0]   s_udp_checksum,

    // source payloads
    input  wire [S_COUNT-1:0]                           s_tvalid,
    output wire [S_COUNT-1:0]                           s_tready,
    input  wire [S_COUNT-1:0][DATA_WIDTH-1:0]           s_tdata,
    input  wire [S_COUNT-1:0]                           s_tlast,
    input  wire [S_COUNT-1:0]                           s_tuser,

    // output header
    output wire                                         m_hdr_valid,
    input  wire                                         m_hdr_ready,
    output wire udp_hdr_pkg::ip_addr_t                  m_ip_source_ip,
    output wire udp_hdr_pkg::ip_addr_t                  m_ip_dest_ip,
    output wire udp_hdr_pkg::udp_port_t                 m_udp_source_port,
    output wire udp_hdr_pkg::udp_port_t                 m_udp_dest_port,
    output wire udp_hdr_pkg::udp_len_t                  m_udp_length,
    output wire udp_hdr_pkg::udp_csum_t                 m_udp_checksum,

    // output payload
    output wire                                         m_tvalid,
    input  wire                                         m_tready,
    output wire [DATA_WIDTH-1:0]                        m_tdata,
    output wire                                         m_tlast,
    output wire                                         m_tuser
);
    import udp_mux_pkg::*;

    localparam int SEL_W = src_index_w(S_COUNT);

    wire                  frame_start;
    wire [SEL_W-1:0]      sel;
    wire                  int_tvalid;
    wire [DATA_WIDTH-1:0] int_tdata;
    wire                  int_tlast;
    wire                  int_tuser;
    wire                  int_tready_early;

    udp_frame_ctrl #(
        .S_COUNT    (S_COUNT),
        .DATA_WIDTH (DATA_WIDTH)
    ) ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .enable           (enable),
        .select           (select),
        .s_hdr_valid      (s_hdr_valid),
        .s_hdr_ready      (s_hdr_ready),
        .s_tvalid         (s_tvalid),
        .s_tready         (s_tready),
        .s_tdata          (s_tdata),
        .s_tlast          (s_tlast),
        .s_tuser          (s_tuser),
        .m_hdr_valid      (m_hdr_valid),
        .frame_start      (frame_start),
        .sel              (sel),
        .int_tvalid       (int_tvalid),
        .int_tdata        (int_tdata),
        .int_tlast        (int_tlast),
        .int_tuser        (int_tuser),
        .int_tready_early (int_tready_early)
    );

    udp_hdr_reg #(
        .S_COUNT (S_COUNT)
    ) hdr_i (
        .clk               (clk),
        .rst               (rst),
        .frame_start       (frame_start),
        .sel               (sel),
        .s_ip_source_ip    (s_ip_source_ip),
        .s_ip_dest_ip      (s_ip_dest_ip),
        .s_udp_source_port (s_udp_source_port),
        .s_udp_dest_port   (s_udp_dest_port),
        .s_udp_length      (s_udp_length),
        .s_udp_checksum    (s_udp_checksum),
        .m_hdr_ready       (m_hdr_ready),
        .m_hdr_valid       (m_hdr_valid),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .m_udp_source_port (m_udp_source_port),
        .m_udp_dest_port   (m_udp_dest_port),
        .m_udp_length      (m_udp_length),
        .m_udp_checksum    (m_udp_checksum)
    );

    axis_skid_buf #(
        .DATA_WIDTH (DATA_WIDTH)
    ) skid_i (
        .clk              (clk),
        .rst              (rst),
        .int_tvalid       (int_tvalid),
        .int_tdata        (int_tdata),
        .int_tlast        (int_tlast),
        .int_tuser        (int_tuser),
        .int_tready_early (int_tready_early),
        .m_tvalid         (m_tvalid),
        .m_tdata          (m_tdata),
        .m_tlast          (m_tlast),
        .m_tuser          (m_tuser),
        .m_tready         (m_tready)
    );

endmodule

`default_nettype wire

// ==== axis_skid_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buf #(
    parameter int DATA_WIDTH = 8
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   int_tvalid,
    input  wire  [DATA_WIDTH-1:0] int_tdata,
    input  wire                   int_tlast,
    input  wire                   int_tuser,
    output logic                  int_tready_early,
    output logic                  m_tvalid,
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic                  m_tlast,
    output logic                  m_tuser,
    input  wire                   m_tready
);

    logic                  int_tready;
    logic                  m_tvalid_next;
    logic                  temp_tvalid;
    logic                  temp_tvalid_next;
    logic [DATA_WIDTH-1:0] temp_tdata;
    logic                  temp_tlast;
    logic                  temp_tuser;
    logic                  store_int_to_out;
    logic                  store_int_to_temp;
    logic                  store_temp_to_out;

    // input may be taken next cycle if the sink drains now, or if
    // the temp entry cannot fill this cycle
    assign int_tready_early = m_tready || (!temp_tvalid && (!m_tvalid || !int_tvalid));

    always_comb begin
        m_tvalid_next     = m_tvalid;
        temp_tvalid_next  = temp_tvalid;
        store_int_to_out  = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (int_tready) begin
            if (m_tready || !m_tvalid) begin
                // output entry free or draining, input goes straight there
                m_tvalid_next    = int_tvalid;
                store_int_to_out = 1'b1;
            end else begin
                // output stalled, park the input in temp
                temp_tvalid_next  = int_tvalid;
                store_int_to_temp = 1'b1;
            end
        end else if (m_tready) begin
            // no input this cycle, temp moves up
            m_tvalid_next     = temp_tvalid;
            temp_tvalid_next  = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid    <= 1'b0;
            temp_tvalid <= 1'b0;
            int_tready  <= 1'b0;
        end else begin
            m_tvalid    <= m_tvalid_next;
            temp_tvalid <= temp_tvalid_next;
            int_tready  <= int_tready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            m_tdata <= int_tdata;
            m_tlast <= int_tlast;
            m_tuser <= int_tuser;
        end else if (store_temp_to_out) begin
            m_tdata <= temp_tdata;
            m_tlast <= temp_tlast;
            m_tuser <= temp_tuser;
        end

        if (store_int_to_temp) begin
            temp_tdata <= int_tdata;
            temp_tlast <= int_tlast;
            temp_tuser <= int_tuser;
        end
    end

    // the temp entry only ever backs up a full output entry
    assert property (@(posedge clk) disable iff (rst) !(temp_tvalid && !m_tvalid))
        else $error("skid temp entry full while output entry empty");

endmodule

`default_nettype wire

// ==== udp_hdr_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_hdr_reg #(
    parameter int S_COUNT = 4
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         frame_start,
    input  wire [udp_mux_pkg::src_index_w(S_COUNT)-1:0] sel,
    input  wire udp_hdr_pkg::ip_addr_t  [S_COUNT-1:0]   s_ip_source_ip,
    input  wire udp_hdr_pkg::ip_addr_t  [S_COUNT-1:0]   s_ip_dest_ip,
    input  wire udp_hdr_pkg::udp_port_t [S_COUNT-1:0]   s_udp_source_port,
    input  wire udp_hdr_pkg::udp_port_t [S_COUNT-1:0]   s_udp_dest_port,
    input  wire udp_hdr_pkg::udp_len_t  [S_COUNT-1:0]   s_udp_length,
    input  wire udp_hdr_pkg::udp_csum_t [S_COUNT-1:0]   s_udp_checksum,
    input  wire                                         m_hdr_ready,
    output logic                                        m_hdr_valid,
    output udp_hdr_pkg::ip_addr_t                       m_ip_source_ip,
    output udp_hdr_pkg::ip_addr_t                       m_ip_dest_ip,
    output udp_hdr_pkg::udp_port_t                      m_udp_source_port,
    output udp_hdr_pkg::udp_port_t                      m_udp_dest_port,
    output udp_hdr_pkg::udp_len_t                       m_udp_length,
    output udp_hdr_pkg::udp_csum_t                      m_udp_checksum
);

    // valid rises one cycle after the start strobe and holds until the sink takes it
    // the controller never starts while valid is still high
    always_ff @(posedge clk) begin
        if (rst) begin
            m_hdr_valid <= 1'b0;
        end else if (frame_start) begin
            m_hdr_valid <= 1'b1;
        end else if (m_hdr_ready) begin
            m_hdr_valid <= 1'b0;
        end
    end

    // field capture from the source named by sel
    always_ff @(posedge clk) begin
        if (frame_start) begin
            m_ip_source_ip    <= s_ip_source_ip[sel];
            m_ip_dest_ip      <= s_ip_dest_ip[sel];
            m_udp_source_port <= s_udp_source_port[sel];
            m_udp_dest_port   <= s_udp_dest_port[sel];
            m_udp_length      <= s_udp_length[sel];
            m_udp_checksum    <= s_udp_checksum[sel];
        end
    end

    // a stalled header keeps its fields until the sink accepts it
    assert property (@(posedge clk) disable iff (rst)
        (m_hdr_valid && !m_hdr_ready) |=>
            $stable({m_ip_source_ip, m_ip_dest_ip, m_udp_source_port,
                     m_udp_dest_port, m_udp_length, m_udp_checksum}))
        else $error("header fields changed while waiting for m_hdr_ready");

endmodule

`default_nettype wire

// ==== udp_frame_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_frame_ctrl #(
    parameter int S_COUNT    = 4,
    parameter int DATA_WIDTH = 8
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire                                          enable,
    input  wire  [udp_mux_pkg::src_index_w(S_COUNT)-1:0] select,
    input  wire  [S_COUNT-1:0]                           s_hdr_valid,
    output logic [S_COUNT-1:0]                           s_hdr_ready,
    input  wire  [S_COUNT-1:0]                           s_tvalid,
    output logic [S_COUNT-1:0]                           s_tready,
    input  wire  [S_COUNT-1:0][DATA_WIDTH-1:0]           s_tdata,
    input  wire  [S_COUNT-1:0]                           s_tlast,
    input  wire  [S_COUNT-1:0]                           s_tuser,
    input  wire                                          m_hdr_valid,
    output logic                                         frame_start,
    output logic [udp_mux_pkg::src_index_w(S_COUNT)-1:0] sel,
    output logic                                         int_tvalid,
    output logic [DATA_WIDTH-1:0]                        int_tdata,
    output logic                                         int_tlast,
    output logic                                         int_tuser,
    input  wire                                          int_tready_early
);
    import udp_mux_pkg::*;

    localparam int SEL_W = src_index_w(S_COUNT);

    frame_state_t       state;
    frame_state_t       state_next;
    logic [SEL_W-1:0]   sel_reg;
    logic [S_COUNT-1:0] sel_onehot;
    logic               cur_tvalid;
    logic               cur_tready;
    logic               beat_done;

    // the latched source owns the payload path for the whole frame
    assign cur_tvalid = s_tvalid[sel_reg];
    assign cur_tready = s_tready[sel_reg];

    // a source beat only counts while a frame is open
    assign beat_done = cur_tvalid && cur_tready && (state == FRAME_ACTIVE);

    // new frame needs an idle controller and a drained header register
    assign frame_start = (state == FRAME_IDLE) && enable && !m_hdr_valid
                         && s_hdr_valid[select];

    // index that the coming edge latches; select is only looked at on a start
    assign sel = frame_start ? select : sel_reg;

    always_comb begin
        sel_onehot = '0;
        sel_onehot[sel] = 1'b1;
    end

    always_comb begin
        state_next = state;
        // end of frame once the last beat is taken
        if (beat_done && s_tlast[sel_reg]) begin
            state_next = FRAME_IDLE;
        end
        if (frame_start) begin
            state_next = FRAME_ACTIVE;
        end
    end

    // internal beat towards the skid buffer
    assign int_tvalid = beat_done;
    assign int_tdata  = s_tdata[sel_reg];
    assign int_tlast  = s_tlast[sel_reg];
    assign int_tuser  = s_tuser[sel_reg];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= FRAME_IDLE;
            sel_reg     <= '0;
            s_hdr_ready <= '0;
            s_tready    <= '0;
        end else begin
            state   <= state_next;
            sel_reg <= sel;
            // header ready is a single cycle pulse on the chosen source
            s_hdr_ready <= frame_start ? sel_onehot : '0;
            // payload ready follows the buffer's early ready, one cycle on
            if (int_tready_early && (state_next == FRAME_ACTIVE)) begin
                s_tready <= sel_onehot;
            end else begin
                s_tready <= '0;
            end
        end
    end

    // payload ready reaches at most one source, and only the latched one
    assert property (@(posedge clk) disable iff (rst)
        (|s_tready) |-> ($onehot(s_tready) && s_tready[sel_reg]))
        else $error("s_tready not limited to the latched source");

endmodule

`default_nettype wire

// ==== udp_mux_pkg.sv ====
`default_nettype none

// frame state and source index helpers for the UDP frame mux
package udp_mux_pkg;

    // idle waits for a header on the selected source,
    // active runs until the beat with last is taken
    typedef enum logic {
        FRAME_IDLE   = 1'b0,
        FRAME_ACTIVE = 1'b1
    } frame_state_t;

    // width of a source index
    // a single source still gets a one bit select
    function automatic int src_index_w(input int count);
        if (count > 1) begin
            return $clog2(count);
        end
        return 1;
    endfunction

endpackage

`default_nettype wire

// ==== udp_hdr_pkg.sv ====
`default_nettype none

// field widths and types of the UDP/IP header words that the mux carries;
// the ethernet and remaining IP fields are not forwarded
package udp_hdr_pkg;

    // IPv4 address
    localparam int IP_ADDR_W = 32;

    // ports, length and checksum are all one 16-bit word
    localparam int UDP_FIELD_W = 16;

    typedef logic [IP_ADDR_W-1:0] ip_addr_t;

    typedef logic [UDP_FIELD_W-1:0] udp_port_t;

    // covers the UDP header plus payload, in bytes
    typedef logic [UDP_FIELD_W-1:0] udp_len_t;

    // zero means the sender did not compute one
    typedef logic [UDP_FIELD_W-1:0] udp_csum_t;

endpackage

`default_nettype wire
